//--- hdl/blackjackPkg.sv
// ================================================
// Shared types and constants for the blackjack game.
// Import with a wildcard in each module header.
// ================================================

package blackjackPkg;

    // rank of a card: ace 1, two..ten 2..10, jack/queen/king 11..13
    typedef logic [3:0] cardRank;

    // point value of a card, ace counted as 1 here
    typedef logic [3:0] cardPoints;

    // best total of one hand
    // hard total never passes 31 since adding stops at bust
    typedef logic [4:0] handSum;

    // public game state
    typedef enum logic [2:0]
    {
        idle,
        dealing,
        playing,
        playerWins,
        dealerWins,
        push
    } gameState;

    // whose move it is
    typedef enum logic [1:0]
    {
        nobody,
        player,
        dealer
    } turnIndicator;

    // key positions on the board, all keys active low
    localparam int KEY_HIT   = 0;
    localparam int KEY_STAND = 1;
    localparam int KEY_DEAL  = 2;

    // dealer stops drawing at this total
    localparam handSum DEALER_STAND_TOTAL = 5'd17;

    // five cards without busting win the hand
    localparam logic [2:0] CHARLIE_CARDS = 3'd5;

endpackage

//--- hdl/keyDebouncer.sv
// ================================================
// Debounces the three active-low push keys.
// One single-cycle command pulse per accepted press.
// ================================================

`timescale 1ns/1ps

module keyDebouncer import blackjackPkg::*;
#(
    parameter int DEBOUNCE_CYCLES = 8
)
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [2:0] KEY,
    output logic       hitPress,
    output logic       standPress,
    output logic       dealPress
);

    localparam int NUM_KEYS = 3;
    localparam int CNT_W    = $clog2(DEBOUNCE_CYCLES + 1);

    // keys read 0 while pressed
    logic [NUM_KEYS-1:0] pressed;
    // debounced level per key
    logic [NUM_KEYS-1:0] stable;
    // registered press pulses
    logic [NUM_KEYS-1:0] pulse;
    // consecutive cycles the raw level differs from stable
    logic [CNT_W-1:0]    count [NUM_KEYS];

    assign pressed = ~KEY;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            stable <= '0;
            pulse  <= '0;
            for (int k = 0; k < NUM_KEYS; k++)
            begin
                count[k] <= '0;
            end
        end
        else
        begin
            for (int k = 0; k < NUM_KEYS; k++)
            begin
                pulse[k] <= 1'b0;
                // raw level agrees with stable, restart the run
                if (pressed[k] == stable[k])
                begin
                    count[k] <= '0;
                end
                // Nth differing sample, accept the new level
                else if (count[k] == CNT_W'(DEBOUNCE_CYCLES - 1))
                begin
                    stable[k] <= pressed[k];
                    // pulse only on the press edge, release is silent
                    pulse[k]  <= pressed[k];
                    count[k]  <= '0;
                end
                else
                begin
                    count[k] <= count[k] + 1'b1;
                end
            end
        end
    end

    assign hitPress   = pulse[KEY_HIT];
    assign standPress = pulse[KEY_STAND];
    assign dealPress  = pulse[KEY_DEAL];

endmodule

//--- hdl/cardSource.sv
// ================================================
// Pseudo-random card source on a free-running LFSR.
// Rank and points are read combinationally; a draw
// takes one extra step so the card is not reused.
// ================================================

`timescale 1ns/1ps

module cardSource import blackjackPkg::*;
#(
    parameter logic [15:0] LFSR_SEED = 16'hACE1
)
(
    input  logic      clk,
    input  logic      rstN,
    input  logic      drawCard,
    output cardRank   rank,
    output cardPoints points
);

    // taps for x^16 + x^14 + x^13 + x^11 + 1, right-shifting Galois form
    localparam logic [15:0] TAP_MASK = 16'hB400;

    logic [15:0] lfsr;
    logic [15:0] stepOnce;
    logic [15:0] stepTwice;
    logic [3:0]  lowBits;

    function automatic logic [15:0] lfsrStep(input logic [15:0] value);
        lfsrStep = (value >> 1) ^ (value[0] ? TAP_MASK : 16'h0000);
    endfunction

    assign stepOnce  = lfsrStep(lfsr);
    assign stepTwice = lfsrStep(stepOnce);

    // always running, so the moment of a key press changes the card
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            lfsr <= LFSR_SEED;
        end
        else
        begin
            lfsr <= drawCard ? stepTwice : stepOnce;
        end
    end

    assign lowBits = lfsr[3:0];

    // fold 0..15 onto 1..13
    always_comb
    begin
        if (lowBits == 4'd0)
        begin
            rank = 4'd13;
        end
        else if (lowBits > 4'd13)
        begin
            rank = lowBits - 4'd13;
        end
        else
        begin
            rank = lowBits;
        end
    end

    // face cards are worth ten
    assign points = (rank > 4'd10) ? 4'd10 : rank;

endmodule

//--- hdl/handAccumulator.sv
// ================================================
// Running total of one hand with soft-ace handling.
// Cleared at the start of a round, one card per add.
// Used twice, once for the player and once for dealer.
// ================================================

`timescale 1ns/1ps

module handAccumulator import blackjackPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       clearHand,
    input  logic       addCard,
    input  cardPoints  points,
    output handSum     sum,
    output logic [2:0] cardCount,
    output logic       blackjack,
    output logic       bust,
    output logic       charlie
);

    // aces counted as 1
    handSum hardTotal;
    // at least one ace in the hand
    logic   hasAce;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            hardTotal <= '0;
            hasAce    <= 1'b0;
            cardCount <= '0;
        end
        else if (clearHand)
        begin
            hardTotal <= '0;
            hasAce    <= 1'b0;
            cardCount <= '0;
        end
        else if (addCard)
        begin
            // points widened to the sum width
            hardTotal <= hardTotal + handSum'(points);
            cardCount <= cardCount + 3'd1;
            if (points == 4'd1)
            begin
                hasAce <= 1'b1;
            end
        end
    end

    // one ace may count 11 when that keeps the hand at 21 or less
    always_comb
    begin
        if (hasAce && (hardTotal <= 5'd11))
        begin
            sum = hardTotal + 5'd10;
        end
        else
        begin
            sum = hardTotal;
        end
    end

    assign bust      = (hardTotal > 5'd21);
    // natural 21 only counts with the first two cards
    assign blackjack = (cardCount == 3'd2) && (sum == 5'd21);
    assign charlie   = (cardCount == CHARLIE_CARDS) && !bust;

endmodule

//--- hdl/blackjackController.sv
// ================================================
// Round controller for the blackjack game.
// Sequences the deal, the player turn, the dealer
// draw loop and the outcome, and drives the card
// draw and hand update strobes.
// ================================================

`timescale 1ns/1ps

module blackjackController import blackjackPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  hitPress,
    input  logic                  standPress,
    input  logic                  dealPress,
    input  handSum                playerSum,
    input  logic                  playerBlackjack,
    input  logic                  playerBust,
    input  logic                  playerCharlie,
    input  handSum                dealerSum,
    input  logic                  dealerBust,
    input  logic                  dealerCharlie,
    output logic                  drawCard,
    output logic                  playerAdd,
    output logic                  dealerAdd,
    output logic                  clearHands,
    output blackjackPkg::gameState gameState,
    output turnIndicator          whoseTurnIsIt
);

    typedef enum logic [3:0]
    {
        sIdle,
        sClear,
        sDealP1,
        sDealP2,
        sDealD,
        sDealCheck,
        sPlayerWait,
        sPlayerHit,
        sPlayerCheck,
        sDealerDraw,
        sDealerCheck,
        sPlayerWin,
        sDealerWin,
        sPush
    } ctrlState;

    ctrlState state;
    ctrlState nextState;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= sIdle;
        end
        else
        begin
            state <= nextState;
        end
    end

    always_comb
    begin
        nextState = state;
        unique case (state)
            sIdle, sPlayerWin, sDealerWin, sPush:
                if (dealPress)
                begin
                    nextState = sClear;
                end
            // deal order is player, player, dealer
            sClear:  nextState = sDealP1;
            sDealP1: nextState = sDealP2;
            sDealP2: nextState = sDealD;
            sDealD:  nextState = sDealCheck;
            // dealer blackjack is not looked at
            sDealCheck:
                nextState = playerBlackjack ? sPlayerWin : sPlayerWait;
            sPlayerWait:
                if (hitPress)
                begin
                    nextState = sPlayerHit;
                end
                else if (standPress)
                begin
                    nextState = sDealerCheck;
                end
            sPlayerHit: nextState = sPlayerCheck;
            // sums of the new card are valid here
            sPlayerCheck:
                if (playerBust)
                begin
                    nextState = sDealerWin;
                end
                else if (playerCharlie)
                begin
                    nextState = sPlayerWin;
                end
                else
                begin
                    nextState = sPlayerWait;
                end
            sDealerDraw: nextState = sDealerCheck;
            sDealerCheck:
                if (dealerBust)
                begin
                    nextState = sPlayerWin;
                end
                else if (dealerCharlie)
                begin
                    nextState = sDealerWin;
                end
                else if (dealerSum < DEALER_STAND_TOTAL)
                begin
                    nextState = sDealerDraw;
                end
                else if (dealerSum > playerSum)
                begin
                    nextState = sDealerWin;
                end
                else if (dealerSum < playerSum)
                begin
                    nextState = sPlayerWin;
                end
                else
                begin
                    nextState = sPush;
                end
            default: nextState = sIdle;
        endcase
    end

    // strobes come straight from the state
    assign clearHands = (state == sClear);
    assign playerAdd  = (state == sDealP1) || (state == sDealP2) || (state == sPlayerHit);
    assign dealerAdd  = (state == sDealD) || (state == sDealerDraw);
    assign drawCard   = playerAdd || dealerAdd;

    // public view of the internal states
    always_comb
    begin
        gameState     = idle;
        whoseTurnIsIt = nobody;
        unique case (state)
            sIdle:                 gameState = idle;
            sClear, sDealCheck:    gameState = dealing;
            sDealP1, sDealP2:
            begin
                gameState     = dealing;
                whoseTurnIsIt = player;
            end
            sDealD:
            begin
                gameState     = dealing;
                whoseTurnIsIt = dealer;
            end
            sPlayerWait, sPlayerHit, sPlayerCheck:
            begin
                gameState     = playing;
                whoseTurnIsIt = player;
            end
            sDealerDraw, sDealerCheck:
            begin
                gameState     = playing;
                whoseTurnIsIt = dealer;
            end
            sPlayerWin:            gameState = playerWins;
            sDealerWin:            gameState = dealerWins;
            sPush:                 gameState = push;
            default:               gameState = idle;
        endcase
    end

endmodule

//--- hdl/blackjackGame.sv
// ================================================
// Top level of the blackjack game.
// Keys in, hand sums, state, turn and dealt cards out.
// ================================================

`timescale 1ns/1ps

module blackjackGame import blackjackPkg::*;
#(
    parameter int          DEBOUNCE_CYCLES = 8,
    parameter logic [15:0] LFSR_SEED       = 16'hACE1
)
(
    input  logic                   clk,
    input  logic                   rstN,
    input  logic [2:0]             KEY,
    output handSum                 playerHandSum,
    output handSum                 dealerHandSum,
    output blackjackPkg::gameState gameState,
    output turnIndicator           whoseTurnIsIt,
    output cardRank                dealtCard,
    output logic                   cardStrobe
);

    // debounced commands
    logic      hitPress;
    logic      standPress;
    logic      dealPress;
    // controller strobes
    logic      drawCard;
    logic      playerAdd;
    logic      dealerAdd;
    logic      clearHands;
    // card value shared by both hands
    cardPoints points;
    // hand flags back to the controller
    logic      playerBlackjack;
    logic      playerBust;
    logic      playerCharlie;
    logic      dealerBust;
    logic      dealerCharlie;

    keyDebouncer #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) keyDebouncer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .KEY       (KEY),
        .hitPress  (hitPress),
        .standPress(standPress),
        .dealPress (dealPress)
    );

    cardSource #(
        .LFSR_SEED(LFSR_SEED)
    ) cardSource_inst (
        .clk     (clk),
        .rstN    (rstN),
        .drawCard(drawCard),
        .rank    (dealtCard),
        .points  (points)
    );

    handAccumulator playerHand (
        .clk      (clk),
        .rstN     (rstN),
        .clearHand(clearHands),
        .addCard  (playerAdd),
        .points   (points),
        .sum      (playerHandSum),
        .cardCount(),
        .blackjack(playerBlackjack),
        .bust     (playerBust),
        .charlie  (playerCharlie)
    );

    // dealer blackjack is not part of the rules here
    handAccumulator dealerHand (
        .clk      (clk),
        .rstN     (rstN),
        .clearHand(clearHands),
        .addCard  (dealerAdd),
        .points   (points),
        .sum      (dealerHandSum),
        .cardCount(),
        .blackjack(),
        .bust     (dealerBust),
        .charlie  (dealerCharlie)
    );

    blackjackController blackjackController_inst (
        .clk            (clk),
        .rstN           (rstN),
        .hitPress       (hitPress),
        .standPress     (standPress),
        .dealPress      (dealPress),
        .playerSum      (playerHandSum),
        .playerBlackjack(playerBlackjack),
        .playerBust     (playerBust),
        .playerCharlie  (playerCharlie),
        .dealerSum      (dealerHandSum),
        .dealerBust     (dealerBust),
        .dealerCharlie  (dealerCharlie),
        .drawCard       (drawCard),
        .playerAdd      (playerAdd),
        .dealerAdd      (dealerAdd),
        .clearHands     (clearHands),
        .gameState      (gameState),
        .whoseTurnIsIt  (whoseTurnIsIt)
    );

    // every draw is shown on the card outputs
    assign cardStrobe = drawCard;

endmodule

//--- testbench/blackjackGame_assertions.sv
// ================================================
// Strobe protocol assertions for the blackjack game.
// Bound into the controller and every hand accumulator.
// ================================================

`timescale 1ns/1ps

module strobeProtocolChecks
(
    input logic clk,
    input logic rstN,
    input logic firstAdd,
    input logic secondAdd,
    input logic clearHand,
    input logic bustFlag,
    input logic charlieFlag
);

    // failed assertions so far, summed by the testbench
    int failCount = 0;

    // a card goes to one hand only
    property singleAdd;
        @(posedge clk) disable iff (!rstN)
            !(firstAdd && secondAdd);
    endproperty

    // clearing and adding never share a cycle
    property clearAlone;
        @(posedge clk) disable iff (!rstN)
            !(clearHand && (firstAdd || secondAdd));
    endproperty

    // five cards over 21 are a bust, not a charlie
    property bustNotCharlie;
        @(posedge clk) disable iff (!rstN)
            !(bustFlag && charlieFlag);
    endproperty

    singleAddCheck: assert property (singleAdd)
    else
    begin
        failCount++;
        $error("player and dealer add strobes high in the same cycle");
    end

    clearAloneCheck: assert property (clearAlone)
    else
    begin
        failCount++;
        $error("hand clear coincides with a card add");
    end

    bustNotCharlieCheck: assert property (bustNotCharlie)
    else
    begin
        failCount++;
        $error("hand flagged as bust and charlie at once");
    end

endmodule

// controller side, player flags as seen by the FSM
bind blackjackController strobeProtocolChecks controllerChecks (
    .clk        (clk),
    .rstN       (rstN),
    .firstAdd   (playerAdd),
    .secondAdd  (dealerAdd),
    .clearHand  (clearHands),
    .bustFlag   (playerBust),
    .charlieFlag(playerCharlie)
);

// each hand has one add strobe
bind handAccumulator strobeProtocolChecks handChecks (
    .clk        (clk),
    .rstN       (rstN),
    .firstAdd   (addCard),
    .secondAdd  (1'b0),
    .clearHand  (clearHand),
    .bustFlag   (bust),
    .charlieFlag(charlie)
);

//--- testbench/blackjackGameTb.sv
// ================================================
// Testbench for the blackjack game top level.
// Presses keys from a command table, tracks every dealt
// card in a hand model and checks sums, state and turn.
// ================================================

`timescale 1ns/1ps

module blackjackGameTb
    import blackjackPkg::*;
();

    localparam int          DEBOUNCE_CYCLES = 4;
    localparam logic [15:0] LFSR_SEED       = 16'hACE1;
    localparam int          CLK_PERIOD      = 20;
    localparam int          RESET_CYCLES    = 16;
    localparam int          SETTLE_LIMIT    = 200;
    localparam int          NUM_STEPS       = 24;
    localparam int          CYCLES_PER_STEP = 300;

    typedef struct {
        int           keyIndex;
        bit           shortPress;
        turnIndicator turnAfter;
    } stepEntry;

    // key, too-short press, turn once an accepted command settles
    stepEntry steps [NUM_STEPS] = '{
        '{KEY_HIT,   1'b0, player},
        '{KEY_STAND, 1'b0, nobody},
        '{KEY_DEAL,  1'b1, player},
        '{KEY_DEAL,  1'b0, player},
        '{KEY_DEAL,  1'b0, player},
        '{KEY_HIT,   1'b1, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_STAND, 1'b0, nobody},
        '{KEY_HIT,   1'b0, player},
        '{KEY_DEAL,  1'b0, player},
        '{KEY_STAND, 1'b0, nobody},
        '{KEY_STAND, 1'b0, nobody},
        '{KEY_DEAL,  1'b0, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_STAND, 1'b0, nobody},
        '{KEY_DEAL,  1'b0, player},
        '{KEY_HIT,   1'b0, player},
        '{KEY_STAND, 1'b0, nobody},
        '{KEY_DEAL,  1'b0, player},
        '{KEY_STAND, 1'b0, nobody}
    };

    logic         clk;
    logic         rstN;
    logic [2:0]   keys;
    handSum       playerSumOut;
    handSum       dealerSumOut;
    gameState     stateOut;
    turnIndicator turnOut;
    cardRank      dealtCard;
    logic         cardStrobe;

    // hand model, aces counted as 1 in the hard totals
    int       playerHard;
    int       dealerHard;
    bit       playerAce;
    bit       dealerAce;
    int       playerCards;
    int       dealerCards;
    int       strobeCount;
    int       errorCount;
    gameState modelState;

    blackjackGame #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .LFSR_SEED      (LFSR_SEED)
    ) blackjackGame_inst (
        .clk          (clk),
        .rstN         (rstN),
        .KEY          (keys),
        .playerHandSum(playerSumOut),
        .dealerHandSum(dealerSumOut),
        .gameState    (stateOut),
        .whoseTurnIsIt(turnOut),
        .dealtCard    (dealtCard),
        .cardStrobe   (cardStrobe)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stopRun();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic failRun(input string reason);
        $display("%s", reason);
        stopRun();
    endtask

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            errorCount++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
            stopRun();
        end
    endtask

    // failures of the protocol assertions bound into the DUT
    function automatic int protocolFailures();
        return blackjackGame_inst.blackjackController_inst.controllerChecks.failCount
            + blackjackGame_inst.playerHand.handChecks.failCount
            + blackjackGame_inst.dealerHand.handChecks.failCount;
    endfunction

    // face cards are worth ten
    function automatic int cardValue(input int rank);
        return (rank > 10) ? 10 : rank;
    endfunction

    // one ace counts 11 if the hand stays at 21 or below
    function automatic int bestTotal(input int hard, input bit hasAce);
        if (hasAce && (hard + 10 <= 21))
        begin
            return hard + 10;
        end
        return hard;
    endfunction

    function automatic bit modelRoundOver();
        return (modelState != playing) && (modelState != dealing);
    endfunction

    // dealer keeps drawing below 17 unless bust or charlie
    function automatic bit dealerStopped();
        if (dealerHard > 21)
        begin
            return 1'b1;
        end
        if (dealerCards == CHARLIE_CARDS)
        begin
            return 1'b1;
        end
        return bestTotal(dealerHard, dealerAce) >= DEALER_STAND_TOTAL;
    endfunction

    // compare the finished dealer hand with the player's
    function automatic gameState standOutcome();
        int playerBest;
        int dealerBest;
        playerBest = bestTotal(playerHard, playerAce);
        dealerBest = bestTotal(dealerHard, dealerAce);
        if (dealerHard > 21)
        begin
            return playerWins;
        end
        else if (dealerCards == CHARLIE_CARDS)
        begin
            return dealerWins;
        end
        else if (dealerBest > playerBest)
        begin
            return dealerWins;
        end
        else if (dealerBest < playerBest)
        begin
            return playerWins;
        end
        return push;
    endfunction

    task automatic clearModel();
        playerHard  = 0;
        dealerHard  = 0;
        playerAce   = 1'b0;
        dealerAce   = 1'b0;
        playerCards = 0;
        dealerCards = 0;
    endtask

    task automatic creditCard(input bit toPlayer, input int rank);
        if (toPlayer)
        begin
            playerHard += cardValue(rank);
            playerCards++;
            playerAce |= (rank == 1);
        end
        else
        begin
            dealerHard += cardValue(rank);
            dealerCards++;
            dealerAce |= (rank == 1);
        end
    endtask

    // card monitor, mid-cycle so strobe and card are settled
    always @(negedge clk)
    begin
        if (rstN && cardStrobe)
        begin
            strobeCount++;
            // ranks run from ace 1 to king 13
            if ((dealtCard < 4'd1) || (dealtCard > 4'd13))
            begin
                failRun($sformatf("dealt card rank %0d is outside ace to king", dealtCard));
            end
            else if (turnOut == player)
            begin
                // first card of a deal sees both hands empty
                if ((stateOut == dealing) && (playerCards == 0))
                begin
                    checkValue("cleared player sum", 0, int'(playerSumOut));
                    checkValue("cleared dealer sum", 0, int'(dealerSumOut));
                end
                creditCard(1'b1, int'(dealtCard));
            end
            else if (turnOut == dealer)
            begin
                if ((stateOut == playing) && dealerStopped())
                begin
                    failRun("dealer drew a card after reaching its stand condition");
                end
                else
                begin
                    creditCard(1'b0, int'(dealtCard));
                end
            end
            else
            begin
                failRun("card strobe while neither hand has the turn");
            end
        end
    end

    // protocol checks bound into the controller and both hands
    always @(negedge clk)
    begin
        if (protocolFailures() != 0)
        begin
            failRun("a bound protocol assertion failed");
        end
    end

    // hold a key for some cycles, then wait out the release debounce
    task automatic pressKey(input int keyIndex, input int holdCycles);
        @(negedge clk);
        keys[keyIndex] = 1'b0;
        repeat (holdCycles) @(negedge clk);
        keys[keyIndex] = 1'b1;
        repeat (DEBOUNCE_CYCLES + 2) @(negedge clk);
    endtask

    task automatic runStep(input int index);
        int           keyIndex;
        bit           accepted;
        int           holdCycles;
        int           strobesBefore;
        int           playerBefore;
        int           waited;
        turnIndicator expectedTurn;
        string        name;
        keyIndex = steps[index].keyIndex;
        name     = $sformatf("step %0d", index);
        if (keyIndex == KEY_DEAL)
        begin
            accepted = modelRoundOver();
        end
        else
        begin
            accepted = (modelState == playing);
        end
        accepted = accepted && !steps[index].shortPress;
        if (accepted && (keyIndex == KEY_DEAL))
        begin
            clearModel();
        end
        strobesBefore = strobeCount;
        playerBefore  = playerCards;
        if (steps[index].shortPress)
        begin
            holdCycles = DEBOUNCE_CYCLES - 1;
        end
        else
        begin
            holdCycles = DEBOUNCE_CYCLES + int'($urandom % (2 * DEBOUNCE_CYCLES + 1));
        end
        pressKey(keyIndex, holdCycles);
        // dealer loop length depends on the cards
        waited = 0;
        while ((stateOut == dealing) || (turnOut == dealer))
        begin
            if (waited == SETTLE_LIMIT)
            begin
                failRun($sformatf("%s did not settle within %0d cycles", name, SETTLE_LIMIT));
            end
            else
            begin
                @(negedge clk);
                waited++;
            end
        end
        if (!accepted)
        begin
            checkValue({name, " strobes"}, 0, strobeCount - strobesBefore);
        end
        else if (keyIndex == KEY_DEAL)
        begin
            checkValue({name, " strobes"}, 3, strobeCount - strobesBefore);
            checkValue({name, " player cards"}, 2, playerCards);
            checkValue({name, " dealer cards"}, 1, dealerCards);
            // natural 21 wins at once, dealer blackjack is not looked at
            if (bestTotal(playerHard, playerAce) == 21)
            begin
                modelState = playerWins;
            end
            else
            begin
                modelState = playing;
            end
        end
        else if (keyIndex == KEY_HIT)
        begin
            checkValue({name, " strobes"}, 1, strobeCount - strobesBefore);
            checkValue({name, " player cards"}, playerBefore + 1, playerCards);
            if (playerHard > 21)
            begin
                modelState = dealerWins;
            end
            else if (playerCards == CHARLIE_CARDS)
            begin
                modelState = playerWins;
            end
        end
        else
        begin
            checkValue({name, " player cards"}, playerBefore, playerCards);
            if (!dealerStopped())
            begin
                failRun($sformatf("%s dealer stood before reaching 17", name));
            end
            else
            begin
                modelState = standOutcome();
            end
        end
        if (modelRoundOver())
        begin
            expectedTurn = nobody;
        end
        else if (accepted)
        begin
            expectedTurn = steps[index].turnAfter;
        end
        else
        begin
            expectedTurn = player;
        end
        checkValue({name, " gameState"}, int'(modelState), int'(stateOut));
        checkValue({name, " turn"}, int'(expectedTurn), int'(turnOut));
        checkValue({name, " player sum"}, bestTotal(playerHard, playerAce), int'(playerSumOut));
        checkValue({name, " dealer sum"}, bestTotal(dealerHard, dealerAce), int'(dealerSumOut));
    endtask

    initial
    begin
        void'($urandom(74));
        keys        = 3'b111;
        rstN        = 1'b0;
        strobeCount = 0;
        errorCount  = 0;
        modelState  = idle;
        clearModel();
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        checkValue("reset gameState", int'(idle), int'(stateOut));
        checkValue("reset turn", int'(nobody), int'(turnOut));
        checkValue("reset player sum", 0, int'(playerSumOut));
        checkValue("reset dealer sum", 0, int'(dealerSumOut));
        // no card may be dealt while idle
        repeat (10) @(negedge clk);
        checkValue("idle strobes", 0, strobeCount);
        for (int i = 0; i < NUM_STEPS; i++)
        begin
            runStep(i);
        end
        if ((errorCount == 0) && (protocolFailures() == 0))
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // bound on the whole run, reset included
    initial
    begin
        #((NUM_STEPS * CYCLES_PER_STEP + RESET_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the command table was finished");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- compile.f
hdl/blackjackPkg.sv
hdl/keyDebouncer.sv
hdl/cardSource.sv
hdl/handAccumulator.sv
hdl/blackjackController.sv
hdl/blackjackGame.sv
testbench/blackjackGame_assertions.sv
testbench/blackjackGameTb.sv

//--- Bender.yml
package:
  name: blackjack_game

sources:
  # shared types first, then leaf modules, then the top level
  - hdl/blackjackPkg.sv
  - hdl/keyDebouncer.sv
  - hdl/cardSource.sv
  - hdl/handAccumulator.sv
  - hdl/blackjackController.sv
  - hdl/blackjackGame.sv

  - target: simulation
    files:
      - testbench/blackjackGame_assertions.sv
      - testbench/blackjackGameTb.sv
